//--- hdl/proc_settings.svh
`ifndef PROC_SETTINGS_SVH
`define PROC_SETTINGS_SVH

// datapath and field widths
`define WORD_W    32 // data and address width, word addressed
`define REG_W     5  // register index
`define OP_W      5
`define ALUOP_W   5
`define SHAMT_W   5
`define IMM_W     17 // raw immediate, sign extended to WORD_W in decode
`define TGT_W     27 // j target, zero extended

// low bit of each field in the instruction word
`define OP_LSB    27
`define RD_LSB    22
`define RS_LSB    17
`define RT_LSB    12
`define SHAMT_LSB 7
`define ALUOP_LSB 2

`define PC_RESET  32'd0

`endif

//--- hdl/isa_pkg.sv
`include "proc_settings.svh"
`default_nettype none

package isa_pkg;

    // major opcodes, bits 31:27
    typedef enum logic [`OP_W-1:0] {
        OP_RTYPE = 5'd0,
        OP_J     = 5'd1,
        OP_BNE   = 5'd2,
        OP_ADDI  = 5'd5,
        OP_BLT   = 5'd6,
        OP_SW    = 5'd7,
        OP_LW    = 5'd8
    } opcode_e;

    // r-type function field
    typedef enum logic [`ALUOP_W-1:0] {
        ALU_ADD = 5'd0,
        ALU_SUB = 5'd1,
        ALU_AND = 5'd2,
        ALU_OR  = 5'd3,
        ALU_SLL = 5'd4,
        ALU_SRA = 5'd5
    } alu_op_e;

    // all fields split out once in decode; all zero is the nop (add r0)
    typedef struct packed {
        opcode_e              opcode;
        logic [`REG_W-1:0]    rd;
        logic [`REG_W-1:0]    rs;
        logic [`REG_W-1:0]    rt;
        logic [`SHAMT_W-1:0]  shamt;
        alu_op_e              alu_op;
        logic [`WORD_W-1:0]   imm;    // already sign extended
        logic [`TGT_W-1:0]    target;
    } instr_t;

    // r-type, addi and lw write rd, never r0
    function automatic logic writes_rd(instr_t i);
        logic kind_ok;
        kind_ok = (i.opcode == OP_RTYPE) || (i.opcode == OP_ADDI) || (i.opcode == OP_LW);
        return kind_ok && (i.rd != '0);
    endfunction

    // second source register: stores and branches read rd on port b
    function automatic logic [`REG_W-1:0] src_b(instr_t i);
        logic rd_src;
        rd_src = (i.opcode == OP_SW) || (i.opcode == OP_BNE) || (i.opcode == OP_BLT);
        return rd_src ? i.rd : i.rt;
    endfunction

endpackage

`default_nettype wire

//--- hdl/pipe_pkg.sv
`include "proc_settings.svh"
`default_nettype none

package pipe_pkg;

    // decode -> execute
    typedef struct packed {
        isa_pkg::instr_t      instr;
        logic [`WORD_W-1:0]   pc_plus1;  // branch base
        logic [`WORD_W-1:0]   reg_a;     // regfile port a, rs
        logic [`WORD_W-1:0]   reg_b;     // regfile port b, rt or rd
    } dx_t;

    // execute -> memory
    typedef struct packed {
        isa_pkg::instr_t      instr;
        logic [`WORD_W-1:0]   result;     // alu result or dmem address
        logic [`WORD_W-1:0]   store_data; // forwarded port b value
    } xm_t;

    // memory -> writeback
    typedef struct packed {
        isa_pkg::instr_t      instr;
        logic [`WORD_W-1:0]   result;
        logic [`WORD_W-1:0]   load_data;  // q_dmem captured at the edge
    } mw_t;

    // where an execute operand comes from
    typedef enum logic [1:0] {
        FWD_REG     = 2'd0, // value read in decode
        FWD_XM_ALU  = 2'd1, // alu result sitting in memory
        FWD_XM_LOAD = 2'd2, // lw in memory, take q_dmem directly
        FWD_WB      = 2'd3  // value being written back
    } fwd_sel_e;

endpackage

`default_nettype wire

//--- hdl/fetch_stage.sv
`include "proc_settings.svh"
`default_nettype none

module fetch_stage (
    input  logic               clock,
    input  logic               rst,
    input  logic               redirect,     // taken branch or j in execute
    input  logic [`WORD_W-1:0] redirect_pc,
    output logic [`WORD_W-1:0] address_imem,
    input  logic [`WORD_W-1:0] q_imem,       // combinational from address_imem
    output logic [`WORD_W-1:0] fd_instr,
    output logic [`WORD_W-1:0] fd_pc_plus1
);

    logic [`WORD_W-1:0] pc;
    logic [`WORD_W-1:0] pc_plus1;
    logic [`WORD_W-1:0] pc_next;

    assign pc_plus1     = pc + `WORD_W'd1; // word addressed, so +1
    assign pc_next      = redirect ? redirect_pc : pc_plus1;
    assign address_imem = pc;

    // pc register, never stalls
    always_ff @(posedge clock) begin
        if (rst) begin
            pc <= `PC_RESET;
        end else begin
            pc <= pc_next;
        end
    end

    // fetch/decode register
    // on redirect the word fetched this cycle is the wrong path and turns into a nop
    always_ff @(posedge clock) begin
        if (rst || redirect) begin
            fd_instr    <= '0;       // nop
            fd_pc_plus1 <= '0;
        end else begin
            fd_instr    <= q_imem;
            fd_pc_plus1 <= pc_plus1; // carried for branch targets
        end
    end

endmodule

`default_nettype wire

//--- hdl/decode_stage.sv
`include "proc_settings.svh"
`default_nettype none

module decode_stage (
    input  logic               clock,
    input  logic               rst,
    input  logic               redirect,
    input  logic [`WORD_W-1:0] fd_instr,
    input  logic [`WORD_W-1:0] fd_pc_plus1,
    output logic [`REG_W-1:0]  ctrl_read_reg_a,
    output logic [`REG_W-1:0]  ctrl_read_reg_b,
    input  logic [`WORD_W-1:0] data_read_reg_a, // regfile writes through, wb value shows here
    input  logic [`WORD_W-1:0] data_read_reg_b,
    output pipe_pkg::dx_t      dx
);

    import isa_pkg::*;
    import pipe_pkg::*;

    instr_t dec;
    dx_t    dx_next;

    // field split, every field decoded whether or not the opcode uses it
    always_comb begin
        dec.opcode = opcode_e'(fd_instr[`OP_LSB +: `OP_W]);
        dec.rd     = fd_instr[`RD_LSB +: `REG_W];
        dec.rs     = fd_instr[`RS_LSB +: `REG_W];
        dec.rt     = fd_instr[`RT_LSB +: `REG_W];
        dec.shamt  = fd_instr[`SHAMT_LSB +: `SHAMT_W];
        dec.alu_op = alu_op_e'(fd_instr[`ALUOP_LSB +: `ALUOP_W]);
        dec.imm    = {{(`WORD_W - `IMM_W){fd_instr[`IMM_W-1]}}, fd_instr[`IMM_W-1:0]};
        dec.target = fd_instr[`TGT_W-1:0];
    end

    assign ctrl_read_reg_a = dec.rs;
    assign ctrl_read_reg_b = src_b(dec); // rd for sw/bne/blt, rt otherwise

    always_comb begin
        dx_next.instr    = dec;
        dx_next.pc_plus1 = fd_pc_plus1;
        dx_next.reg_a    = data_read_reg_a;
        dx_next.reg_b    = data_read_reg_b;
    end

    // decode/execute register
    // the instruction in decode is younger than a redirecting branch, squash it
    always_ff @(posedge clock) begin
        if (rst || redirect) begin
            dx <= '0;
        end else begin
            dx <= dx_next;
        end
    end

endmodule

`default_nettype wire

//--- hdl/bypass_unit.sv
`include "proc_settings.svh"
`default_nettype none

module bypass_unit (
    input  pipe_pkg::dx_t      dx,
    input  pipe_pkg::xm_t      xm,
    input  pipe_pkg::mw_t      mw,
    output pipe_pkg::fwd_sel_e fwd_a,
    output pipe_pkg::fwd_sel_e fwd_b
);

    import isa_pkg::*;
    import pipe_pkg::*;

    logic [`REG_W-1:0] src_a_reg;
    logic [`REG_W-1:0] src_b_reg;

    // memory is younger than writeback so it is checked last and overrides
    function automatic fwd_sel_e pick_src(
        logic [`REG_W-1:0] src,
        instr_t            xm_i,
        instr_t            mw_i
    );
        fwd_sel_e sel;
        sel = FWD_REG;
        if (writes_rd(mw_i) && (mw_i.rd == src)) begin
            sel = FWD_WB;
        end
        if (writes_rd(xm_i) && (xm_i.rd == src)) begin
            // lw data is only on q_dmem during the memory cycle
            sel = (xm_i.opcode == OP_LW) ? FWD_XM_LOAD : FWD_XM_ALU;
        end
        return sel;
    endfunction

    // same source choice as the regfile read in decode
    assign src_a_reg = dx.instr.rs;
    assign src_b_reg = src_b(dx.instr);

    // r0 never matches since writes_rd rejects rd 0
    assign fwd_a = pick_src(src_a_reg, xm.instr, mw.instr);
    assign fwd_b = pick_src(src_b_reg, xm.instr, mw.instr);

endmodule

`default_nettype wire

//--- hdl/execute_stage.sv
`include "proc_settings.svh"
`default_nettype none

module execute_stage (
    input  logic               clock,
    input  logic               rst,
    input  pipe_pkg::dx_t      dx,
    input  pipe_pkg::fwd_sel_e fwd_a,
    input  pipe_pkg::fwd_sel_e fwd_b,
    input  logic [`WORD_W-1:0] xm_result,   // alu result of the memory stage
    input  logic [`WORD_W-1:0] q_dmem,      // load data of the memory stage
    input  logic [`WORD_W-1:0] wb_value,    // value on the regfile write port
    output pipe_pkg::xm_t      xm,
    output logic               redirect,    // combinational, one cycle
    output logic [`WORD_W-1:0] redirect_pc
);

    import isa_pkg::*;
    import pipe_pkg::*;

    logic [`WORD_W-1:0] op_a;    // rs value
    logic [`WORD_W-1:0] op_b;    // rt, or rd for sw and branches
    logic [`WORD_W-1:0] alu_out;
    logic               ne;
    logic               lt;
    xm_t                xm_next;

    function automatic logic [`WORD_W-1:0] fwd_mux(
        fwd_sel_e           sel,
        logic [`WORD_W-1:0] reg_val,
        logic [`WORD_W-1:0] alu_val,
        logic [`WORD_W-1:0] load_val,
        logic [`WORD_W-1:0] wb_val
    );
        logic [`WORD_W-1:0] v;
        case (sel)
            FWD_XM_ALU:  v = alu_val;
            FWD_XM_LOAD: v = load_val;
            FWD_WB:      v = wb_val;
            default:     v = reg_val;
        endcase
        return v;
    endfunction

    assign op_a = fwd_mux(fwd_a, dx.reg_a, xm_result, q_dmem, wb_value);
    assign op_b = fwd_mux(fwd_b, dx.reg_b, xm_result, q_dmem, wb_value);

    always_comb begin
        alu_out = op_a + dx.instr.imm; // addi, and the lw/sw address
        if (dx.instr.opcode == OP_RTYPE) begin
            case (dx.instr.alu_op)
                ALU_SUB: alu_out = op_a - op_b;
                ALU_AND: alu_out = op_a & op_b;
                ALU_OR:  alu_out = op_a | op_b;
                ALU_SLL: alu_out = op_a << dx.instr.shamt;
                ALU_SRA: alu_out = $unsigned($signed(op_a) >>> dx.instr.shamt); // sign fill
                default: alu_out = op_a + op_b; // add, also the nop
            endcase
        end
    end

    // branch compares are rd against rs
    assign ne = (op_b != op_a);
    assign lt = ($signed(op_b) < $signed(op_a));

    always_comb begin
        redirect    = 1'b0;
        redirect_pc = dx.pc_plus1 + dx.instr.imm; // pc relative
        case (dx.instr.opcode)
            OP_BNE: redirect = ne;
            OP_BLT: redirect = lt;
            OP_J: begin
                redirect    = 1'b1;
                redirect_pc = {{(`WORD_W - `TGT_W){1'b0}}, dx.instr.target};
            end
            default: redirect = 1'b0;
        endcase
    end

    always_comb begin
        xm_next.instr      = dx.instr;
        xm_next.result     = alu_out;
        xm_next.store_data = op_b; // sw data register, forwarded
    end

    // execute/memory register
    always_ff @(posedge clock) begin
        if (rst) begin
            xm <= '0;
        end else begin
            xm <= xm_next;
        end
    end

endmodule

`default_nettype wire

//--- hdl/memory_writeback.sv
`include "proc_settings.svh"
`default_nettype none

module memory_writeback (
    input  logic               clock,
    input  logic               rst,
    input  pipe_pkg::xm_t      xm,
    input  logic [`WORD_W-1:0] q_dmem,
    output logic [`WORD_W-1:0] address_dmem,
    output logic [`WORD_W-1:0] data,
    output logic               wren,
    output pipe_pkg::mw_t      mw,
    output logic               ctrl_write_enable,
    output logic [`REG_W-1:0]  ctrl_write_reg,
    output logic [`WORD_W-1:0] data_write_reg    // also the wb bypass value
);

    import isa_pkg::*;
    import pipe_pkg::*;

    mw_t mw_next;

    // memory side, store lands at the next edge
    assign address_dmem = xm.result;
    assign data         = xm.store_data;
    assign wren         = (xm.instr.opcode == OP_SW);

    always_comb begin
        mw_next.instr     = xm.instr;
        mw_next.result    = xm.result;
        mw_next.load_data = q_dmem; // meaningful only for lw
    end

    // memory/writeback register
    always_ff @(posedge clock) begin
        if (rst) begin
            mw <= '0;
        end else begin
            mw <= mw_next;
        end
    end

    // writeback strobe straight off the register
    assign ctrl_write_enable = writes_rd(mw.instr);
    assign ctrl_write_reg    = mw.instr.rd;
    assign data_write_reg    = (mw.instr.opcode == OP_LW) ? mw.load_data : mw.result;

endmodule

`default_nettype wire

//--- hdl/processor.sv
`include "proc_settings.svh"
`default_nettype none

module processor (
    input  logic               clock,
    input  logic               rst,
    // instruction memory
    output logic [`WORD_W-1:0] address_imem,
    input  logic [`WORD_W-1:0] q_imem,
    // data memory
    output logic [`WORD_W-1:0] address_dmem,
    output logic [`WORD_W-1:0] data,
    output logic               wren,
    input  logic [`WORD_W-1:0] q_dmem,
    // register file
    output logic               ctrl_write_enable,
    output logic [`REG_W-1:0]  ctrl_write_reg,
    output logic [`REG_W-1:0]  ctrl_read_reg_a,
    output logic [`REG_W-1:0]  ctrl_read_reg_b,
    output logic [`WORD_W-1:0] data_write_reg,
    input  logic [`WORD_W-1:0] data_read_reg_a,
    input  logic [`WORD_W-1:0] data_read_reg_b
);

    import pipe_pkg::*;

    logic [`WORD_W-1:0] fd_instr;
    logic [`WORD_W-1:0] fd_pc_plus1;
    logic               redirect;    // flushes fetch and decode
    logic [`WORD_W-1:0] redirect_pc;
    dx_t                dx;
    xm_t                xm;
    mw_t                mw;
    fwd_sel_e           fwd_a;
    fwd_sel_e           fwd_b;

    fetch_stage fetch_i (
        .clock, .rst, .redirect, .redirect_pc,
        .address_imem, .q_imem, .fd_instr, .fd_pc_plus1
    );

    decode_stage decode_i (
        .clock, .rst, .redirect, .fd_instr, .fd_pc_plus1,
        .ctrl_read_reg_a, .ctrl_read_reg_b, .data_read_reg_a, .data_read_reg_b, .dx
    );

    bypass_unit bypass_i (.dx, .xm, .mw, .fwd_a, .fwd_b);

    execute_stage execute_i (
        .clock, .rst, .dx, .fwd_a, .fwd_b,
        .xm_result (xm.result),       // memory stage alu result
        .q_dmem,
        .wb_value  (data_write_reg),  // writeback mux output
        .xm, .redirect, .redirect_pc
    );

    memory_writeback mem_wb_i (
        .clock, .rst, .xm, .q_dmem, .address_dmem, .data, .wren, .mw,
        .ctrl_write_enable, .ctrl_write_reg, .data_write_reg
    );

endmodule

`default_nettype wire

//--- tb/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// instruction encoders, field layout of the isa
function automatic logic [31:0] enc_r(int fn, int rd, int rs, int rt, int sh);
    return {5'd0, rd[4:0], rs[4:0], rt[4:0], sh[4:0], fn[4:0], 2'b00};
endfunction

function automatic logic [31:0] enc_i(int op, int rd, int rs, int imm);
    return {op[4:0], rd[4:0], rs[4:0], imm[16:0]}; // addi, lw, sw, bne, blt
endfunction

function automatic logic [31:0] enc_j(int target);
    return {5'd1, target[26:0]};
endfunction

function automatic logic [31:0] fill_word(int addr); // dmem contents after reset
    return {addr[7:0], ~addr[7:0], addr[7:0] ^ 8'h5a, 8'hc3};
endfunction

logic [31:0] lcg_state = 32'h1f19;

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
endfunction

// in order interpreter of imem[0..n-1], queues every register write and store
task automatic run_model(input int n);
    logic [31:0] r [0:31];
    logic [31:0] m [0:255];
    logic [31:0] w, a, b, imm, addr, res;
    logic [4:0]  op, rd;
    int          pc;
    int          i;
    for (i = 0; i < 32; i++)
        r[i] = '0;
    for (i = 0; i < 256; i++)
        m[i] = fill_word(i);
    pc = 0;
    i = 0;
    while (pc < n && i < 4000) begin  // step bound
        w    = imem[pc];
        op   = w[31:27];
        rd   = w[26:22];
        a    = r[w[21:17]];            // rs
        b    = r[w[16:12]];            // rt
        imm  = {{15{w[16]}}, w[16:0]};
        addr = a + imm;
        res  = addr;                   // addi
        pc   = pc + 1;
        i    = i + 1;
        case (op)
            5'd0: case (w[6:2])
                5'd1:    res = a - b;
                5'd2:    res = a & b;
                5'd3:    res = a | b;
                5'd4:    res = a << w[11:7];
                5'd5:    res = $signed(a) >>> w[11:7];
                default: res = a + b;
            endcase
            5'd8: res = m[addr[7:0]];
            5'd7: begin
                m[addr[7:0]] = r[rd];  // sw data comes from rd
                exp_st.push_back({addr, r[rd]});
            end
            5'd2: if (r[rd] != a) pc = pc + imm;
            5'd6: if ($signed(r[rd]) < $signed(a)) pc = pc + imm;
            5'd1: pc = w[26:0];
            default: ;
        endcase
        if ((op == 5'd0 || op == 5'd5 || op == 5'd8) && rd != 5'd0) begin
            r[rd] = res;
            exp_wr.push_back({rd, res});
        end
    end
endtask

`endif

//--- tb/processor_tb.sv
`default_nettype none

module processor_tb;

    logic        clock = 1'b0;
    logic        rst = 1'b1;                // changes on the falling edge
    logic [31:0] address_imem, q_imem, address_dmem, data, q_dmem;
    logic        wren, ctrl_write_enable;
    logic [4:0]  ctrl_write_reg, ctrl_read_reg_a, ctrl_read_reg_b;
    logic [31:0] data_write_reg, data_read_reg_a, data_read_reg_b;
    logic [31:0] imem [0:511];              // zero past the program, so nops
    logic [31:0] dmem [0:255];
    logic [31:0] regs [0:31];
    logic [36:0] exp_wr [$];                // {rd, value} in program order
    logic [63:0] exp_st [$];                // {address, data}
    logic [36:0] wr_head;
    logic [63:0] st_head;
    int          prog_len;
    int          mismatches = 0;
    int          failures = 0;              // timeouts, unexpected strobes

    `include "tb_model.svh"

    processor dut_i (
        .clock, .rst, .address_imem, .q_imem, .address_dmem, .data, .wren, .q_dmem,
        .ctrl_write_enable, .ctrl_write_reg, .ctrl_read_reg_a, .ctrl_read_reg_b,
        .data_write_reg, .data_read_reg_a, .data_read_reg_b
    );

    always #50 clock = ~clock;

    assign q_imem = (address_imem < 32'd512) ? imem[address_imem[8:0]] : '0;
    assign q_dmem = dmem[address_dmem[7:0]];
    // regfile writes through, r0 reads zero
    assign data_read_reg_a = (ctrl_write_enable && ctrl_write_reg == ctrl_read_reg_a &&
                              ctrl_read_reg_a != 5'd0) ? data_write_reg : regs[ctrl_read_reg_a];
    assign data_read_reg_b = (ctrl_write_enable && ctrl_write_reg == ctrl_read_reg_b &&
                              ctrl_read_reg_b != 5'd0) ? data_write_reg : regs[ctrl_read_reg_b];

    always @(posedge clock) begin
        if (ctrl_write_enable && ctrl_write_reg != 5'd0)
            regs[ctrl_write_reg] <= data_write_reg;
        if (wren)
            dmem[address_dmem[7:0]] <= data;   // store lands at this edge
    end

    // each strobe pops its queue, outputs settled since the falling edge
    always @(posedge clock) begin
        if (!rst && ctrl_write_enable) begin
            assert (exp_wr.size() > 0) else begin
                failures++;
                $display("register write to r%0d at %0t with none expected", ctrl_write_reg, $time);
            end
            if (exp_wr.size() > 0) begin
                wr_head = exp_wr.pop_front();
                assert ({ctrl_write_reg, data_write_reg} == wr_head) else begin
                    mismatches++;
                    $display("Mismatch at %0t: r%0d <= %h, expected r%0d <= %h", $time,
                             ctrl_write_reg, data_write_reg, wr_head[36:32], wr_head[31:0]);
                end
            end
        end
        if (!rst && wren) begin
            assert (exp_st.size() > 0) else begin
                failures++;
                $display("store to %h at %0t with none expected", address_dmem, $time);
            end
            if (exp_st.size() > 0) begin
                st_head = exp_st.pop_front();
                assert ({address_dmem, data} == st_head) else begin
                    mismatches++;
                    $display("Mismatch at %0t: mem[%h] <= %h, expected mem[%h] <= %h", $time,
                             address_dmem, data, st_head[63:32], st_head[31:0]);
                end
            end
        end
    end

    task automatic new_program();
        int i;
        rst = 1'b1;                         // core held while imem changes
        prog_len = 0;
        for (i = 0; i < 512; i++)
            imem[i] = '0;
    endtask

    task automatic put(input logic [31:0] w);
        imem[prog_len] = w;
        prog_len++;
    endtask

    // alu ops and addi over r0..r7, no branches or memory
    task automatic make_random(input int n);
        logic [31:0] r;
        int          k;
        repeat (n) begin
            r = lcg_next();
            k = r[31:16] % 7;               // 0..5 alu op, 6 addi
            if (k == 6)
                put(enc_i(5, r[10:8], r[13:11], {{20{r[27]}}, r[27:16]}));
            else
                put(enc_r(k, r[10:8], r[13:11], r[6:4], r[20:16]));
        end
    endtask

    task automatic run_program(input string name);
        int i;
        for (i = 0; i < 32; i++)
            regs[i] = '0;
        for (i = 0; i < 256; i++)
            dmem[i] = fill_word(i);
        run_model(prog_len);
        repeat (4) @(negedge clock);
        rst = 1'b0;
        i = 0;
        while ((exp_wr.size() > 0 || exp_st.size() > 0) && i < 3000) begin
            @(negedge clock);
            i++;
        end
        if (exp_wr.size() > 0 || exp_st.size() > 0) begin
            failures++;
            $display("%s: timed out with %0d writes and %0d stores still expected",
                     name, exp_wr.size(), exp_st.size());
            exp_wr.delete();
            exp_st.delete();
        end
        repeat (8) @(negedge clock);        // a stray late write still gets caught
    endtask

    initial begin
        new_program();                      // forwarding on both operands
        put(enc_i(5, 1, 0, 5));
        put(enc_i(5, 2, 0, -3));
        put(enc_r(0, 3, 1, 2, 0));          // a from writeback, b from memory
        put(enc_r(1, 4, 3, 1, 0));          // a from memory, b via write through
        put(enc_r(4, 5, 4, 0, 3));
        put(enc_r(5, 6, 2, 0, 1));          // sra of a negative value
        put(enc_r(3, 7, 6, 5, 0));          // a memory, b writeback
        put(enc_r(2, 0, 7, 3, 0));          // rd 0 never strobes
        run_program("forwarding");
        new_program();
        put(enc_i(5, 1, 0, 10));
        put(enc_i(8, 2, 1, 3));             // lw r2, 3(r1)
        put(enc_r(0, 3, 2, 1, 0));          // load used at once, from q_dmem
        put(enc_i(7, 3, 1, 0));             // sw data from memory stage
        put(enc_i(5, 4, 0, 7));
        put(enc_i(5, 5, 0, 1));
        put(enc_i(7, 4, 5, 20));            // data from writeback, base from memory
        put(enc_i(8, 6, 1, 0));             // reads back the first store
        put(enc_r(0, 7, 1, 6, 0));
        put(enc_i(8, 2, 5, 20));
        put(enc_i(7, 2, 0, 30));            // store data straight off q_dmem
        run_program("load and store");
        new_program();
        put(enc_i(5, 1, 0, -4));
        put(enc_i(5, 2, 0, 3));
        put(enc_i(2, 1, 2, 2));             // bne taken
        put(enc_i(5, 3, 0, 99));            // flushed
        put(enc_i(5, 4, 0, 99));            // flushed
        put(enc_i(6, 1, 2, 2));             // blt -4 < 3 taken
        put(enc_i(5, 5, 0, 99));
        put(enc_i(5, 6, 0, 99));
        put(enc_i(6, 2, 1, 5));             // blt 3 < -4 not taken
        put(enc_i(2, 1, 1, 5));             // bne equal, not taken
        put(enc_i(5, 3, 0, 1));
        put(enc_j(14));
        put(enc_i(5, 4, 0, 99));
        put(enc_i(5, 5, 0, 99));
        put(enc_i(5, 6, 0, 2));
        run_program("branches");
        new_program();
        make_random(200);
        run_program("random");
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+hdl
+incdir+tb
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/bypass_unit.sv
hdl/execute_stage.sv
hdl/memory_writeback.sv
hdl/processor.sv
tb/processor_tb.sv
